/* hw/mapperPkg.sv */
`default_nettype none

package mapperPkg;

	localparam int PIXEL_W = 10;
	localparam int COORD_W = 11;
	localparam int RGB_W = 24;
	localparam int COLOR_IDX_W = 4;

	typedef enum logic [1:0] {
		up = 2'd0,
		right = 2'd1,
		down = 2'd2,
		left = 2'd3
	} dirT;

	typedef enum logic [1:0] {
		rest1 = 2'd0,
		move1 = 2'd1,
		rest2 = 2'd2,
		move2 = 2'd3
	} stepT;

	// Sprite sheet and on-screen character window
	localparam int SHEET_W = 228;
	localparam int SPRITE_W = 19;
	localparam int SPRITE_H = 29;
	localparam int SHEET_DEPTH = SHEET_W * SPRITE_H;
	localparam int SPRITE_ADDR_W = $clog2(SHEET_DEPTH);
	localparam int CHAR_X0 = 311;
	localparam int CHAR_Y0 = 340;

	// Map cells are 4x4 screen pixels
	localparam int MAP_SHIFT = 2;

	// Entry 0 is never shown since index 0 is transparent
	localparam logic [0:15][RGB_W-1:0] SPRITE_PALETTE = {
		24'h0080ff, 24'h050507, 24'h565656, 24'h384040,
		24'hf7af20, 24'hd8a078, 24'hb66f20, 24'hf8d0b8,
		24'hb8b0d0, 24'h968fae, 24'he7e7f7, 24'hc03838,
		24'hed6747, 24'h0b6ed1, 24'h5e3233, 24'h2e3340
	};

	// Indexed by dirT and stepT
	localparam logic [0:3][7:0] DIR_COLUMN = {8'd114, 8'd171, 8'd0, 8'd57};
	localparam logic [0:3][7:0] STEP_COLUMN = {8'd19, 8'd0, 8'd19, 8'd38};

	localparam int AXI_ADDR_W = 20;
	localparam int AXI_DATA_W = 32;

	localparam logic [AXI_ADDR_W-1:0] CONTROL_ADDR = 20'h00000;
	localparam logic [AXI_ADDR_W-1:0] POSITION_ADDR = 20'h00004;
	localparam logic [AXI_ADDR_W-1:0] ANIM_ADDR = 20'h00008;
	localparam logic [AXI_ADDR_W-1:0] SPRITE_BASE = 20'h40000;
	localparam logic [AXI_ADDR_W-1:0] MAP_BASE = 20'h80000;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hw/videoMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module videoMemory #(
	parameter int DEPTH = 1024,
	parameter int WIDTH = 8
) (
	input  logic Clk,
	input  logic we,
	input  logic [$clog2(DEPTH)-1:0] wAddr,
	input  logic [WIDTH-1:0] wData,
	input  logic [$clog2(DEPTH)-1:0] rAddr,
	output logic [WIDTH-1:0] rData
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge Clk) begin
		if (we) begin
			mem[wAddr] <= wData;
		end
		rData <= mem[rAddr];
	end

endmodule

`default_nettype wire

/* hw/mapperRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module mapperRegs
	import mapperPkg::*;
#(
	parameter int MAP_W = 320,
	parameter int MAP_H = 240
) (
	input  logic Clk,
	input  logic rstN,
	input  logic awvalid,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	output logic awready,
	input  logic wvalid,
	input  logic [AXI_DATA_W-1:0] wdata,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input  logic bready,
	input  logic arvalid,
	input  logic [AXI_ADDR_W-1:0] araddr,
	output logic arready,
	output logic rvalid,
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	input  logic rready,
	output logic moving,
	output dirT direction,
	input  logic [COORD_W-1:0] originX,
	input  logic [COORD_W-1:0] originY,
	input  dirT facing,
	input  stepT step,
	output logic spriteWe,
	output logic [SPRITE_ADDR_W-1:0] spriteAddr,
	output logic [COLOR_IDX_W-1:0] spriteData,
	output logic mapWe,
	output logic [$clog2(MAP_W*MAP_H)-1:0] mapAddr,
	output logic [RGB_W-1:0] mapData
);

	localparam int MAP_DEPTH = MAP_W * MAP_H;
	localparam int MAP_ADDR_W = $clog2(MAP_DEPTH);

	logic wrAccept;
	logic rdAccept;
	logic ctrlHit;
	logic spriteHit;
	logic mapHit;
	logic rdOk;
	logic [AXI_DATA_W-1:0] rdValue;

	// Address and data channels are taken in the same cycle
	assign awready = wrAccept;
	assign wready = wrAccept;
	assign arready = rdAccept;

	assign ctrlHit = (awaddr == CONTROL_ADDR);
	assign spriteHit = (awaddr >= SPRITE_BASE) && (awaddr < SPRITE_BASE + 4 * SHEET_DEPTH);
	assign mapHit = (awaddr >= MAP_BASE) && (awaddr < MAP_BASE + 4 * MAP_DEPTH);

	// Memory strobes fire on the handshake edge itself
	assign spriteWe = wrAccept && spriteHit;
	assign spriteAddr = SPRITE_ADDR_W'((awaddr - SPRITE_BASE) >> 2);
	assign spriteData = wdata[COLOR_IDX_W-1:0];
	assign mapWe = wrAccept && mapHit;
	assign mapAddr = MAP_ADDR_W'((awaddr - MAP_BASE) >> 2);
	assign mapData = wdata[RGB_W-1:0];

	always_comb begin
		rdOk = 1'b1;
		rdValue = '0;
		case (araddr)
			CONTROL_ADDR: rdValue = AXI_DATA_W'({direction, moving});
			POSITION_ADDR: begin
				rdValue[COORD_W-1:0] = originX;
				rdValue[16 +: COORD_W] = originY;
			end
			ANIM_ADDR: rdValue = AXI_DATA_W'({step, facing});
			default: rdOk = 1'b0;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			wrAccept <= 1'b0;
			rdAccept <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			moving <= 1'b0;
			direction <= up;
		end else begin
			wrAccept <= awvalid && wvalid && !bvalid && !wrAccept;
			rdAccept <= arvalid && !rvalid && !rdAccept;
			if (wrAccept) begin
				bvalid <= 1'b1;
				if (ctrlHit) begin
					moving <= wdata[0];
					direction <= dirT'(wdata[2:1]);
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rdAccept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (wrAccept) begin
			bresp <= (ctrlHit || spriteHit || mapHit) ? RESP_OKAY : RESP_SLVERR;
		end
		if (rdAccept) begin
			rdata <= rdValue;
			rresp <= rdOk ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

/* hw/walkController.sv */
`timescale 1ns/1ps
`default_nettype none

module walkController
	import mapperPkg::*;
#(
	parameter int ORIGIN_X0 = 100,
	parameter int ORIGIN_Y0 = 100,
	parameter int STEP_HOLD = 8
) (
	input  logic Clk,
	input  logic rstN,
	input  logic frameStart,
	input  logic moving,
	input  dirT direction,
	output logic [COORD_W-1:0] originX,
	output logic [COORD_W-1:0] originY,
	output dirT facing,
	output stepT step
);

	localparam int HOLD_W = (STEP_HOLD > 1) ? $clog2(STEP_HOLD) : 1;

	logic [HOLD_W-1:0] holdCount;
	stepT stepNext;

	always_comb begin
		case (step)
			rest1: stepNext = move1;
			move1: stepNext = rest2;
			rest2: stepNext = move2;
			default: stepNext = rest1;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			originX <= COORD_W'(ORIGIN_X0);
			originY <= COORD_W'(ORIGIN_Y0);
			facing <= up;
			step <= rest1;
			holdCount <= '0;
		end else if (frameStart) begin
			if (!moving) begin
				step <= rest1;
			end else if (direction != facing) begin
				// Turning costs one frame and does not scroll
				facing <= direction;
				step <= rest1;
			end else begin
				case (facing)
					up: originY <= originY - 1'b1;
					down: originY <= originY + 1'b1;
					right: originX <= originX + 1'b1;
					default: originX <= originX - 1'b1;
				endcase
				if (holdCount == '0) begin
					step <= stepNext;
				end
				if (holdCount == HOLD_W'(STEP_HOLD - 1)) begin
					holdCount <= '0;
				end else begin
					holdCount <= holdCount + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/pixelFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelFetch
	import mapperPkg::*;
#(
	parameter int MAP_W = 320,
	parameter int MAP_H = 240
) (
	input  logic Clk,
	input  logic rstN,
	input  logic [PIXEL_W-1:0] drawX,
	input  logic [PIXEL_W-1:0] drawY,
	input  logic videoOn,
	input  logic [COORD_W-1:0] originX,
	input  logic [COORD_W-1:0] originY,
	input  dirT facing,
	input  stepT step,
	input  logic spriteWe,
	input  logic [SPRITE_ADDR_W-1:0] spriteAddr,
	input  logic [COLOR_IDX_W-1:0] spriteData,
	input  logic mapWe,
	input  logic [$clog2(MAP_W*MAP_H)-1:0] mapAddr,
	input  logic [RGB_W-1:0] mapData,
	output logic [COLOR_IDX_W-1:0] spriteIndex,
	output logic [RGB_W-1:0] mapColor,
	output logic charHere,
	output logic inBounds,
	output logic videoOnQ
);

	localparam int MAP_DEPTH = MAP_W * MAP_H;
	localparam int MAP_ADDR_W = $clog2(MAP_DEPTH);

	logic charWin;
	logic [PIXEL_W-1:0] relX;
	logic [PIXEL_W-1:0] relY;
	logic [SPRITE_ADDR_W-1:0] spriteRdAddr;
	logic [COORD_W:0] sumX;
	logic [COORD_W:0] sumY;
	logic [COORD_W-MAP_SHIFT:0] cellX;
	logic [COORD_W-MAP_SHIFT:0] cellY;
	logic [MAP_ADDR_W-1:0] mapRdAddr;

	assign charWin = (drawX >= CHAR_X0) && (drawX < CHAR_X0 + SPRITE_W) &&
		(drawY >= CHAR_Y0) && (drawY < CHAR_Y0 + SPRITE_H);

	// Frame column picked by facing and step
	assign relX = drawX - PIXEL_W'(CHAR_X0);
	assign relY = drawY - PIXEL_W'(CHAR_Y0);
	assign spriteRdAddr = charWin ? SPRITE_ADDR_W'(SHEET_W * relY + relX +
		DIR_COLUMN[facing] + STEP_COLUMN[step]) : '0;

	// Scrolled screen position scaled down to map cells
	assign sumX = {1'b0, originX} + (COORD_W+1)'(drawX);
	assign sumY = {1'b0, originY} + (COORD_W+1)'(drawY);
	assign cellX = sumX[COORD_W:MAP_SHIFT];
	assign cellY = sumY[COORD_W:MAP_SHIFT];
	assign mapRdAddr = MAP_ADDR_W'(cellY * MAP_W + cellX);

	videoMemory #(
		.DEPTH(SHEET_DEPTH),
		.WIDTH(COLOR_IDX_W)
	) spriteSheet (
		.Clk(Clk),
		.we(spriteWe),
		.wAddr(spriteAddr),
		.wData(spriteData),
		.rAddr(spriteRdAddr),
		.rData(spriteIndex)
	);

	videoMemory #(
		.DEPTH(MAP_DEPTH),
		.WIDTH(RGB_W)
	) mapMemory (
		.Clk(Clk),
		.we(mapWe),
		.wAddr(mapAddr),
		.wData(mapData),
		.rAddr(mapRdAddr),
		.rData(mapColor)
	);

	// Flags delayed to meet the memory read data
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			charHere <= 1'b0;
			inBounds <= 1'b0;
			videoOnQ <= 1'b0;
		end else begin
			charHere <= charWin;
			inBounds <= (cellX < MAP_W) && (cellY < MAP_H);
			videoOnQ <= videoOn;
		end
	end

endmodule

`default_nettype wire

/* hw/pixelColorizer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelColorizer
	import mapperPkg::*;
(
	input  logic Clk,
	input  logic rstN,
	input  logic [COLOR_IDX_W-1:0] spriteIndex,
	input  logic [RGB_W-1:0] mapColor,
	input  logic charHere,
	input  logic inBounds,
	input  logic videoOnQ,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	logic [RGB_W-1:0] colorNext;

	always_comb begin
		if (!videoOnQ || !inBounds) begin
			colorNext = '0;
		end else if (charHere && spriteIndex != '0) begin
			// Sprite wins over the map where it is opaque
			colorNext = SPRITE_PALETTE[spriteIndex];
		end else begin
			colorNext = mapColor;
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			{red, green, blue} <= colorNext;
		end
	end

endmodule

`default_nettype wire

/* hw/colorMapperTop.sv */
`timescale 1ns/1ps
`default_nettype none

module colorMapperTop
	import mapperPkg::*;
#(
	parameter int MAP_W = 320,
	parameter int MAP_H = 240,
	parameter int ORIGIN_X0 = 100,
	parameter int ORIGIN_Y0 = 100,
	parameter int STEP_HOLD = 8
) (
	input  logic Clk,
	input  logic rstN,
	input  logic awvalid,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	output logic awready,
	input  logic wvalid,
	input  logic [AXI_DATA_W-1:0] wdata,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input  logic bready,
	input  logic arvalid,
	input  logic [AXI_ADDR_W-1:0] araddr,
	output logic arready,
	output logic rvalid,
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	input  logic rready,
	input  logic [PIXEL_W-1:0] drawX,
	input  logic [PIXEL_W-1:0] drawY,
	input  logic videoOn,
	input  logic frameStart,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	localparam int MAP_ADDR_W = $clog2(MAP_W * MAP_H);

	logic moving;
	dirT direction;
	logic [COORD_W-1:0] originX;
	logic [COORD_W-1:0] originY;
	dirT facing;
	stepT step;

	logic spriteWe;
	logic [SPRITE_ADDR_W-1:0] spriteAddr;
	logic [COLOR_IDX_W-1:0] spriteData;
	logic mapWe;
	logic [MAP_ADDR_W-1:0] mapAddr;
	logic [RGB_W-1:0] mapData;

	logic [COLOR_IDX_W-1:0] spriteIndex;
	logic [RGB_W-1:0] mapColor;
	logic charHere;
	logic inBounds;
	logic videoOnQ;

	mapperRegs #(
		.MAP_W(MAP_W),
		.MAP_H(MAP_H)
	) mapperRegs_i (
		.Clk(Clk),
		.rstN(rstN),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.awready(awready),
		.wvalid(wvalid),
		.wdata(wdata),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.arvalid(arvalid),
		.araddr(araddr),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.moving(moving),
		.direction(direction),
		.originX(originX),
		.originY(originY),
		.facing(facing),
		.step(step),
		.spriteWe(spriteWe),
		.spriteAddr(spriteAddr),
		.spriteData(spriteData),
		.mapWe(mapWe),
		.mapAddr(mapAddr),
		.mapData(mapData)
	);

	walkController #(
		.ORIGIN_X0(ORIGIN_X0),
		.ORIGIN_Y0(ORIGIN_Y0),
		.STEP_HOLD(STEP_HOLD)
	) walkController_i (
		.Clk(Clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.moving(moving),
		.direction(direction),
		.originX(originX),
		.originY(originY),
		.facing(facing),
		.step(step)
	);

	pixelFetch #(
		.MAP_W(MAP_W),
		.MAP_H(MAP_H)
	) pixelFetch_i (
		.Clk(Clk),
		.rstN(rstN),
		.drawX(drawX),
		.drawY(drawY),
		.videoOn(videoOn),
		.originX(originX),
		.originY(originY),
		.facing(facing),
		.step(step),
		.spriteWe(spriteWe),
		.spriteAddr(spriteAddr),
		.spriteData(spriteData),
		.mapWe(mapWe),
		.mapAddr(mapAddr),
		.mapData(mapData),
		.spriteIndex(spriteIndex),
		.mapColor(mapColor),
		.charHere(charHere),
		.inBounds(inBounds),
		.videoOnQ(videoOnQ)
	);

	pixelColorizer pixelColorizer_i (
		.Clk(Clk),
		.rstN(rstN),
		.spriteIndex(spriteIndex),
		.mapColor(mapColor),
		.charHere(charHere),
		.inBounds(inBounds),
		.videoOnQ(videoOnQ),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

`default_nettype wire

/* tests/mapperRegs_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mapperRegsProperties (
	input logic Clk,
	input logic rstN,
	input logic awready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);

	// Responses stay up until the host takes them
	bvalidHold: assert property (@(posedge Clk) disable iff (!rstN)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready was seen");

	rvalidHold: assert property (@(posedge Clk) disable iff (!rstN)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready was seen");

	// No new write accepted while a response is pending
	noAcceptWhilePending: assert property (@(posedge Clk) disable iff (!rstN)
		!(awready && bvalid))
		else $error("awready high while bvalid is pending");

endmodule

bind mapperRegs mapperRegsProperties mapperRegsProperties_i (
	.Clk(Clk),
	.rstN(rstN),
	.awready(awready),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready)
);

`default_nettype wire

/* tests/colorMapperTb.sv */
`timescale 1ns/1ps
`default_nettype none

module colorMapperTb
	import mapperPkg::*;
();

	localparam int TIMEOUT_CYCLES = 32;
	localparam int MAP_COLS = 320;
	localparam int HOLD_FRAMES = 8;

	logic Clk;
	logic rstN;
	logic awvalid;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awready;
	logic wvalid;
	logic [AXI_DATA_W-1:0] wdata;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic bready;
	logic arvalid;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arready;
	logic rvalid;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rready;
	logic [PIXEL_W-1:0] drawX;
	logic [PIXEL_W-1:0] drawY;
	logic videoOn;
	logic frameStart;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	int errorCount = 0;
	int checkCount = 0;
	logic [31:0] lfsrState = 32'h8a08c0b2;

	// Walker model
	int modelX;
	int modelY;
	int modelHold;
	dirT modelFacing;
	stepT modelStep;

	// Screen points well away from the character window
	int probeX [5] = '{0, 37, 600, 200, 639};
	int probeY [5] = '{0, 5, 100, 450, 479};
	logic [23:0] cellColor [5];

	colorMapperTop colorMapperTop_i (.*);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'ha3000000) : (lfsrState >> 1);
		end
		return value;
	endfunction

	function automatic int mapCell(input int x, input int y);
		return ((y + modelY) >> 2) * MAP_COLS + ((x + modelX) >> 2);
	endfunction

	function automatic int frameColumn(input dirT f, input stepT s);
		int col;
		case (f)
			up: col = 114;
			right: col = 171;
			down: col = 0;
			default: col = 57;
		endcase
		if (s == move2) begin
			col = col + 38;
		end else if (s != move1) begin
			col = col + 19;
		end
		return col;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic axiWrite(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int cycles;
		bit done;
		resp = 2'b11;
		@(posedge Clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(negedge Clk);
			done = awready && wready;
			cycles++;
		end
		// Handshake edge
		@(posedge Clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		if (!done) begin
			errorCount++;
			$display("Write to 0x%05h was never accepted", addr);
		end else begin
			cycles = 0;
			done = 1'b0;
			while (!done && cycles < TIMEOUT_CYCLES) begin
				@(negedge Clk);
				done = bvalid;
				cycles++;
			end
			if (!done) begin
				errorCount++;
				$display("Write to 0x%05h got no write response", addr);
			end else begin
				resp = bresp;
				@(posedge Clk);
				bready <= 1'b1;
				@(posedge Clk);
				bready <= 1'b0;
			end
		end
	endtask

	task automatic axiRead(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cycles;
		bit done;
		data = '0;
		resp = 2'b11;
		@(posedge Clk);
		arvalid <= 1'b1;
		araddr <= addr;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(negedge Clk);
			done = arready;
			cycles++;
		end
		@(posedge Clk);
		arvalid <= 1'b0;
		if (!done) begin
			errorCount++;
			$display("Read from 0x%05h was never accepted", addr);
		end else begin
			cycles = 0;
			done = 1'b0;
			while (!done && cycles < TIMEOUT_CYCLES) begin
				@(negedge Clk);
				done = rvalid;
				cycles++;
			end
			if (!done) begin
				errorCount++;
				$display("Read from 0x%05h returned no data", addr);
			end else begin
				data = rdata;
				resp = rresp;
				@(posedge Clk);
				rready <= 1'b1;
				@(posedge Clk);
				rready <= 1'b0;
			end
		end
	endtask

	task automatic writeReg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [1:0] expResp);
		logic [1:0] resp;
		axiWrite(addr, data, resp);
		checkValue("bresp", 32'(resp), 32'(expResp));
	endtask

	task automatic readReg(input logic [AXI_ADDR_W-1:0] addr, input string name,
		input logic [31:0] expData, input logic [1:0] expResp);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(addr, data, resp);
		checkValue("rresp", 32'(resp), 32'(expResp));
		if (expResp == RESP_OKAY) begin
			checkValue(name, data, expData);
		end
	endtask

	// RGB shows up two edges after the pixel is sampled
	task automatic probePixel(input int x, input int y, input logic on,
		input logic [23:0] expected, input string name);
		@(posedge Clk);
		drawX <= PIXEL_W'(x);
		drawY <= PIXEL_W'(y);
		videoOn <= on;
		@(posedge Clk);
		// Pixel is on screen for one cycle only
		videoOn <= 1'b0;
		@(posedge Clk);
		@(negedge Clk);
		checkValue(name, {8'h00, red, green, blue}, {8'h00, expected});
	endtask

	task automatic pulseFrame();
		@(posedge Clk);
		frameStart <= 1'b1;
		@(posedge Clk);
		frameStart <= 1'b0;
	endtask

	task automatic modelFrame(input logic moving, input dirT dir);
		if (!moving) begin
			modelStep = rest1;
		end else if (dir != modelFacing) begin
			modelFacing = dir;
			modelStep = rest1;
		end else begin
			case (modelFacing)
				up: modelY--;
				down: modelY++;
				right: modelX++;
				default: modelX--;
			endcase
			// Step order follows the encoding
			if (modelHold == 0) begin
				modelStep = stepT'(modelStep + 2'd1);
			end
			modelHold = (modelHold + 1) % HOLD_FRAMES;
		end
	endtask

	task automatic checkWalker();
		readReg(POSITION_ADDR, "position", {5'b0, 11'(modelY), 5'b0, 11'(modelX)}, RESP_OKAY);
		readReg(ANIM_ADDR, "anim", {28'b0, modelStep, modelFacing}, RESP_OKAY);
	endtask

	task automatic mapPixel(input int x, input int y);
		logic [23:0] color;
		color = randomBits(24);
		writeReg(AXI_ADDR_W'(MAP_BASE + 4 * mapCell(x, y)), 32'(color), RESP_OKAY);
		probePixel(x, y, 1'b1, color, "map rgb");
	endtask

	// Index 0 lets the map cell underneath show through
	task automatic overlayPixel(input int rx, input int ry, input logic [3:0] idx);
		int x;
		int y;
		int sheet;
		logic [23:0] color;
		x = CHAR_X0 + rx;
		y = CHAR_Y0 + ry;
		sheet = SHEET_W * ry + rx + frameColumn(modelFacing, modelStep);
		writeReg(AXI_ADDR_W'(SPRITE_BASE + 4 * sheet), 32'(idx), RESP_OKAY);
		if (idx == 4'd0) begin
			color = randomBits(24);
			writeReg(AXI_ADDR_W'(MAP_BASE + 4 * mapCell(x, y)), 32'(color), RESP_OKAY);
		end else begin
			color = SPRITE_PALETTE[idx];
		end
		probePixel(x, y, 1'b1, color, "sprite rgb");
	endtask

	task automatic testRegisterAccess();
		checkWalker();
		writeReg(CONTROL_ADDR, 32'h5, RESP_OKAY);
		readReg(CONTROL_ADDR, "control", 32'h5, RESP_OKAY);
		writeReg(CONTROL_ADDR, 32'h0, RESP_OKAY);
		readReg(CONTROL_ADDR, "control", 32'h0, RESP_OKAY);
		writeReg(POSITION_ADDR, 32'h0001_0001, RESP_SLVERR);
		writeReg(20'h0000c, 32'h1, RESP_SLVERR);
		readReg(20'h00010, "unmapped", 32'h0, RESP_SLVERR);
		checkWalker();
	endtask

	task automatic testMapRendering();
		for (int i = 0; i < 5; i++) begin
			cellColor[i] = randomBits(24);
			writeReg(AXI_ADDR_W'(MAP_BASE + 4 * mapCell(probeX[i], probeY[i])),
				32'(cellColor[i]), RESP_OKAY);
		end
		for (int i = 0; i < 5; i++) begin
			probePixel(probeX[i], probeY[i], 1'b1, cellColor[i], "map rgb");
		end
	endtask

	task automatic testBlanking();
		probePixel(probeX[0], probeY[0], 1'b0, 24'h0, "blanked rgb");
		probePixel(10, 900, 1'b1, 24'h0, "out of bounds rgb");
		probePixel(probeX[0], probeY[0], 1'b1, cellColor[0], "map rgb");
	endtask

	task automatic testSpriteOverlay();
		overlayPixel(0, 0, 4'd1);
		overlayPixel(5, 3, 4'(randomBits(4)) | 4'h2);
		overlayPixel(9, 14, 4'd0);
		overlayPixel(18, 28, 4'hf);
	endtask

	task automatic testWalking();
		writeReg(CONTROL_ADDR, 32'h3, RESP_OKAY);
		// Turn frame
		pulseFrame();
		modelFrame(1'b1, right);
		checkWalker();
		for (int i = 0; i < 20; i++) begin
			pulseFrame();
			modelFrame(1'b1, right);
			checkWalker();
		end
		writeReg(CONTROL_ADDR, 32'h2, RESP_OKAY);
		pulseFrame();
		modelFrame(1'b0, right);
		checkWalker();
		mapPixel(50, 60);
		overlayPixel(4, 10, 4'd7);
		overlayPixel(12, 2, 4'd0);
	endtask

	initial begin
		rstN <= 1'b0;
		awvalid <= 1'b0;
		awaddr <= '0;
		wvalid <= 1'b0;
		wdata <= '0;
		bready <= 1'b0;
		arvalid <= 1'b0;
		araddr <= '0;
		rready <= 1'b0;
		drawX <= '0;
		drawY <= '0;
		videoOn <= 1'b0;
		frameStart <= 1'b0;
		modelX = 100;
		modelY = 100;
		modelHold = 0;
		modelFacing = up;
		modelStep = rest1;
		repeat (2) @(posedge Clk);
		rstN <= 1'b1;

		testRegisterAccess();
		testMapRendering();
		testBlanking();
		testSpriteOverlay();
		testWalking();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hw/mapperPkg.sv
hw/videoMemory.sv
hw/mapperRegs.sv
hw/walkController.sv
hw/pixelFetch.sv
hw/pixelColorizer.sv
hw/colorMapperTop.sv
tests/mapperRegs_properties.sv
tests/colorMapperTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module colorMapperTb \
	-f list.f -o simv > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -qx "RESULT: PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
